// File: logic/plot_pkg.sv
package plot_pkg;

  // ************************************************************************
  // raster and sample sizes
  // ************************************************************************

  localparam int ADC_BITS    = 10;
  localparam int COLOR_WIDTH = 4;
  localparam int PIXEL_BITS  = 3 * COLOR_WIDTH;
  localparam int COORD_BITS  = 6;

  localparam int H_VISIBLE = 64;
  localparam int V_VISIBLE = 48;

  localparam int FB_WORDS     = H_VISIBLE * V_VISIBLE;
  localparam int FB_ADDR_BITS = $clog2(FB_WORDS);
  localparam int FB_DATA_BITS = 16;

  // coordinate = sample * size / 2**SCALE_SHIFT
  localparam int SCALE_SHIFT = ADC_BITS;
  localparam int SCALE_BITS  = ADC_BITS + COORD_BITS;

  // colour bits trail the position channels by this many samples
  localparam int ADC_DELAY = 3;

  // ************************************************************************
  // types
  // ************************************************************************

  typedef logic [ADC_BITS-1:0] adc_sample_t;
  typedef logic [COORD_BITS-1:0] coord_x_t;
  typedef logic [COORD_BITS-1:0] coord_y_t;

  // red in the top nibble, blue in the bottom one
  typedef logic [PIXEL_BITS-1:0] pixel_t;

  typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;
  typedef logic [FB_DATA_BITS-1:0] fb_data_t;

  localparam pixel_t BLACK = '0;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_CLEAR,
    SEQ_PLOT
  } seq_state_t;

endpackage

// File: logic/plot_seq.sv
`timescale 1ns/1ps

module plot_seq (
  input  logic              clk,
  input  logic              rst_n,

  output logic              sweep_start,
  input  logic              sweep_done,

  input  logic              fill_valid,
  input  plot_pkg::coord_x_t fill_x,
  input  plot_pkg::coord_y_t fill_y,
  input  plot_pkg::pixel_t  fill_pixel,
  output logic              fill_ready,

  input  logic              plot_valid,
  input  plot_pkg::coord_x_t plot_x,
  input  plot_pkg::coord_y_t plot_y,
  input  plot_pkg::pixel_t  plot_pixel,
  output logic              plot_ready,

  output logic              pix_valid,
  output plot_pkg::coord_x_t pix_x,
  output plot_pkg::coord_y_t pix_y,
  output plot_pkg::pixel_t  pix_pixel,
  input  logic              pix_ready,

  output logic              plotting
);
  import plot_pkg::*;

  seq_state_t state;
  seq_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      SEQ_IDLE:  state_next = SEQ_CLEAR;
      SEQ_CLEAR: if (sweep_done) state_next = SEQ_PLOT;
      SEQ_PLOT:  state_next = SEQ_PLOT;
      default:   state_next = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= SEQ_IDLE;
      sweep_start <= 1'b0;
    end else begin
      state       <= state_next;
      sweep_start <= (state == SEQ_IDLE);
    end
  end

  // stream mux, only the selected source sees ready
  always_comb begin
    pix_valid  = 1'b0;
    pix_x      = '0;
    pix_y      = '0;
    pix_pixel  = BLACK;
    fill_ready = 1'b0;
    plot_ready = 1'b0;
    case (state)
      SEQ_CLEAR: begin
        pix_valid  = fill_valid;
        pix_x      = fill_x;
        pix_y      = fill_y;
        pix_pixel  = fill_pixel;
        fill_ready = pix_ready;
      end
      SEQ_PLOT: begin
        pix_valid  = plot_valid;
        pix_x      = plot_x;
        pix_y      = plot_y;
        pix_pixel  = plot_pixel;
        plot_ready = pix_ready;
      end
      default: ;
    endcase
  end

  assign plotting = (state == SEQ_PLOT);

endmodule

// File: logic/raster_sweep.sv
`timescale 1ns/1ps

module raster_sweep (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               sweep_start,
  output logic               sweep_done,

  output logic               fill_valid,
  output plot_pkg::coord_x_t fill_x,
  output plot_pkg::coord_y_t fill_y,
  output plot_pkg::pixel_t   fill_pixel,
  input  logic               fill_ready
);
  import plot_pkg::*;

  localparam coord_x_t X_LAST = coord_x_t'(H_VISIBLE - 1);
  localparam coord_y_t Y_LAST = coord_y_t'(V_VISIBLE - 1);

  logic active;
  logic xfer;

  assign xfer = active && fill_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active     <= 1'b0;
      sweep_done <= 1'b0;
      fill_x     <= '0;
      fill_y     <= '0;
    end else begin
      sweep_done <= 1'b0;
      if (sweep_start) begin
        active <= 1'b1;
        fill_x <= '0;
        fill_y <= '0;
      end else if (xfer) begin
        // x first, then wrap into the next line
        if (fill_x == X_LAST) begin
          fill_x <= '0;
          if (fill_y == Y_LAST) begin
            active     <= 1'b0;
            sweep_done <= 1'b1;
          end else begin
            fill_y <= fill_y + 1'b1;
          end
        end else begin
          fill_x <= fill_x + 1'b1;
        end
      end
    end
  end

  assign fill_valid = active;
  assign fill_pixel = BLACK;

endmodule

// File: logic/adc_xy_sampler.sv
`timescale 1ns/1ps

module adc_xy_sampler (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  plotting,

  input  logic                  adc_valid,
  input  plot_pkg::adc_sample_t adc_x,
  input  plot_pkg::adc_sample_t adc_y,
  input  logic                  adc_red,
  input  logic                  adc_grn,
  input  logic                  adc_blu,
  output logic                  adc_ready,

  output logic                  plot_valid,
  output plot_pkg::coord_x_t    plot_x,
  output plot_pkg::coord_y_t    plot_y,
  output plot_pkg::pixel_t      plot_pixel,
  input  logic                  plot_ready
);
  import plot_pkg::*;

  localparam int WARM_BITS = $clog2(ADC_DELAY + 1);

  logic [2:0]            color_line [ADC_DELAY];
  logic [WARM_BITS-1:0]  warm_cnt;
  logic                  warm;
  logic                  accept;
  logic [SCALE_BITS-1:0] prod_x;
  logic [SCALE_BITS-1:0] prod_y;
  logic [2:0]            rgb_old;

  // holding register is free when empty or draining this cycle
  assign adc_ready = plotting && (!plot_valid || plot_ready);
  assign accept    = adc_valid && adc_ready;
  assign warm      = (warm_cnt == WARM_BITS'(ADC_DELAY));

  assign prod_x  = SCALE_BITS'(adc_x * H_VISIBLE);
  assign prod_y  = SCALE_BITS'(adc_y * V_VISIBLE);
  assign rgb_old = color_line[ADC_DELAY-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      plot_valid <= 1'b0;
      warm_cnt   <= '0;
    end else begin
      if (plot_valid && plot_ready) plot_valid <= 1'b0;
      if (accept) begin
        if (warm) plot_valid <= 1'b1;
        else warm_cnt <= warm_cnt + 1'b1;
      end
    end
  end

  // colour delay line and output payload
  always_ff @(posedge clk) begin
    if (accept) begin
      color_line[0] <= {adc_red, adc_grn, adc_blu};
      for (int i = 1; i < ADC_DELAY; i++) begin
        color_line[i] <= color_line[i-1];
      end
      plot_x     <= prod_x[SCALE_SHIFT+:COORD_BITS];
      plot_y     <= prod_y[SCALE_SHIFT+:COORD_BITS];
      plot_pixel <= {{COLOR_WIDTH{rgb_old[2]}}, {COLOR_WIDTH{rgb_old[1]}},
                     {COLOR_WIDTH{rgb_old[0]}}};
    end
  end

endmodule

// File: logic/fb_apb_writer.sv
`timescale 1ns/1ps

module fb_apb_writer (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               pix_valid,
  input  plot_pkg::coord_x_t pix_x,
  input  plot_pkg::coord_y_t pix_y,
  input  plot_pkg::pixel_t   pix_pixel,
  output logic               pix_ready,

  output logic               psel,
  output logic               penable,
  output logic               pwrite,
  output plot_pkg::fb_addr_t paddr,
  output plot_pkg::fb_data_t pwdata,
  input  logic               pready,
  input  logic               pslverr,

  output logic               fb_error
);
  import plot_pkg::*;

  logic     accept;
  logic     done;
  fb_addr_t pix_addr;

  // ************************************************************************
  // address and handshake
  // ************************************************************************

  assign pix_addr  = fb_addr_t'(pix_y * H_VISIBLE + pix_x);
  assign pix_ready = !psel;
  assign accept    = pix_valid && pix_ready;
  assign done      = psel && penable && pready;

  // idle (psel low), setup (penable low), access (penable high)
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psel     <= 1'b0;
      penable  <= 1'b0;
      fb_error <= 1'b0;
    end else begin
      if (accept) begin
        psel    <= 1'b1;
        penable <= 1'b0;
      end else if (psel && !penable) begin
        penable <= 1'b1;
      end else if (done) begin
        psel    <= 1'b0;
        penable <= 1'b0;
        if (pslverr) fb_error <= 1'b1;
      end
    end
  end

  // ************************************************************************
  // payload, held for the whole transfer
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (accept) begin
      paddr  <= pix_addr;
      pwdata <= fb_data_t'(pix_pixel);
    end
  end

  // the framebuffer port never reads
  assign pwrite = 1'b1;

endmodule

// File: logic/adc_plot_top.sv
`timescale 1ns/1ps

module adc_plot_top (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  adc_valid,
  input  plot_pkg::adc_sample_t adc_x,
  input  plot_pkg::adc_sample_t adc_y,
  input  logic                  adc_red,
  input  logic                  adc_grn,
  input  logic                  adc_blu,
  output logic                  adc_ready,

  output logic                  psel,
  output logic                  penable,
  output logic                  pwrite,
  output plot_pkg::fb_addr_t    paddr,
  output plot_pkg::fb_data_t    pwdata,
  input  logic                  pready,
  input  logic                  pslverr,

  output logic                  fb_error,
  output logic                  plotting
);
  import plot_pkg::*;

  logic     sweep_start;
  logic     sweep_done;

  // clear fill stream
  logic     fill_valid;
  coord_x_t fill_x;
  coord_y_t fill_y;
  pixel_t   fill_pixel;
  logic     fill_ready;

  // sampled plot stream
  logic     plot_valid;
  coord_x_t plot_x;
  coord_y_t plot_y;
  pixel_t   plot_pixel;
  logic     plot_ready;

  // selected stream into the framebuffer port
  logic     pix_valid;
  coord_x_t pix_x;
  coord_y_t pix_y;
  pixel_t   pix_pixel;
  logic     pix_ready;

  plot_seq plot_seq_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sweep_start(sweep_start),
    .sweep_done (sweep_done),
    .fill_valid (fill_valid),
    .fill_x     (fill_x),
    .fill_y     (fill_y),
    .fill_pixel (fill_pixel),
    .fill_ready (fill_ready),
    .plot_valid (plot_valid),
    .plot_x     (plot_x),
    .plot_y     (plot_y),
    .plot_pixel (plot_pixel),
    .plot_ready (plot_ready),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_pixel  (pix_pixel),
    .pix_ready  (pix_ready),
    .plotting   (plotting)
  );

  raster_sweep raster_sweep_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sweep_start(sweep_start),
    .sweep_done (sweep_done),
    .fill_valid (fill_valid),
    .fill_x     (fill_x),
    .fill_y     (fill_y),
    .fill_pixel (fill_pixel),
    .fill_ready (fill_ready)
  );

  adc_xy_sampler adc_xy_sampler_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .plotting  (plotting),
    .adc_valid (adc_valid),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .adc_red   (adc_red),
    .adc_grn   (adc_grn),
    .adc_blu   (adc_blu),
    .adc_ready (adc_ready),
    .plot_valid(plot_valid),
    .plot_x    (plot_x),
    .plot_y    (plot_y),
    .plot_pixel(plot_pixel),
    .plot_ready(plot_ready)
  );

  fb_apb_writer fb_apb_writer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_valid(pix_valid),
    .pix_x    (pix_x),
    .pix_y    (pix_y),
    .pix_pixel(pix_pixel),
    .pix_ready(pix_ready),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .fb_error (fb_error)
  );

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  logic por_n;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // power-on reset held for the first 8 rising edges
  initial begin
    por_n = 1'b0;
    repeat (8) @(posedge clk);
    por_n <= 1'b1;
  end

  assign rst_n = por_n && !rst_req;

endmodule

// File: dv/fb_apb_model.sv
`timescale 1ns/1ps

module fb_apb_model #(
  parameter int unsigned SEED = 0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  plot_pkg::fb_addr_t paddr,
  input  plot_pkg::fb_data_t pwdata,
  input  int                 err_at,
  output logic               pready,
  output logic               pslverr
);
  import plot_pkg::*;

  localparam int LOG_DEPTH = 8192;

  fb_data_t mem [FB_WORDS];
  fb_addr_t log_addr [LOG_DEPTH];
  fb_data_t log_data [LOG_DEPTH];
  int       wr_count;
  int       stalls;

  // single responder process, so the seeded generator is the one that draws
  initial begin
    int unsigned wait_left;
    void'($urandom(SEED));
    pready    = 1'b0;
    pslverr   = 1'b0;
    wr_count  = 0;
    stalls    = 0;
    wait_left = 0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        pready    <= 1'b0;
        pslverr   <= 1'b0;
        wait_left = 0;
      end else if (psel && !penable) begin
        // setup cycle seen, pick 0 to 3 wait states for the access phase
        wait_left = $urandom_range(3, 0);
        pready  <= (wait_left == 0);
        pslverr <= (wait_left == 0) && (wr_count == err_at);
      end else if (psel && penable && pready) begin
        if (pwrite) begin
          if (paddr < FB_WORDS) mem[paddr] <= pwdata;
          if (wr_count < LOG_DEPTH) begin
            log_addr[wr_count] <= paddr;
            log_data[wr_count] <= pwdata;
          end
          wr_count <= wr_count + 1;
        end
        pready  <= 1'b0;
        pslverr <= 1'b0;
      end else if (psel && penable) begin
        wait_left = wait_left - 1;
        stalls  <= stalls + 1;
        pready  <= (wait_left == 0);
        pslverr <= (wait_left == 0) && (wr_count == err_at);
      end
    end
  end

endmodule

// File: dv/plot_tb.sv
`timescale 1ns/1ps

module plot_tb;
  import plot_pkg::*;

  localparam int unsigned SEED = 32'h19e6_72d7;
  localparam int TIMEOUT_CYCLES = 50000;
  localparam int N_STIM = 12;

  logic        clk;
  logic        rst_n;
  logic        rst_req;
  logic        adc_valid;
  adc_sample_t adc_x;
  adc_sample_t adc_y;
  logic        adc_red;
  logic        adc_grn;
  logic        adc_blu;
  logic        adc_ready;
  logic        psel;
  logic        penable;
  logic        pwrite;
  fb_addr_t    paddr;
  fb_data_t    pwdata;
  logic        pready;
  logic        pslverr;
  logic        fb_error;
  logic        plotting;
  int          err_at;

  // stimulus table, expected values worked out from the scaling and delay rules
  adc_sample_t stim_x [N_STIM];
  adc_sample_t stim_y [N_STIM];
  logic [2:0]  stim_rgb [N_STIM];
  logic        stim_wr [N_STIM];
  fb_addr_t    stim_addr [N_STIM];
  pixel_t      stim_pix [N_STIM];
  int          n_stim;
  int          n_writes;

  // framebuffer contents expected after the plot writes
  pixel_t      fb_img [FB_WORDS];

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;

  tb_clkgen clkgen0 (
    .rst_req(rst_req),
    .clk    (clk),
    .rst_n  (rst_n)
  );

  adc_plot_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .adc_valid(adc_valid),
    .adc_x    (adc_x),
    .adc_y    (adc_y),
    .adc_red  (adc_red),
    .adc_grn  (adc_grn),
    .adc_blu  (adc_blu),
    .adc_ready(adc_ready),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .fb_error (fb_error),
    .plotting (plotting)
  );

  fb_apb_model #(.SEED(SEED)) fb_model0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .err_at (err_at),
    .pready (pready),
    .pslverr(pslverr)
  );

  // **************************************************************************
  // table and compare helpers
  // **************************************************************************

  task automatic add_entry(input adc_sample_t x, input adc_sample_t y, input logic [2:0] rgb,
                           input logic wr, input fb_addr_t addr, input pixel_t pix);
    stim_x[n_stim]    = x;
    stim_y[n_stim]    = y;
    stim_rgb[n_stim]  = rgb;
    stim_wr[n_stim]   = wr;
    stim_addr[n_stim] = addr;
    stim_pix[n_stim]  = pix;
    if (wr) n_writes++;
    n_stim++;
  endtask

  task automatic check_addr(input string name, input fb_addr_t exp, input fb_addr_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s FAILED with %0d errors", name, errors - err0);
    end
  endtask

  task automatic wait_for_writes(input int target);
    int cycles;
    cycles = 0;
    while (fb_model0.wr_count < target && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (fb_model0.wr_count < target) begin
      errors++;
      timed_out = 1'b1;
      $display("timed out waiting for write %0d, only %0d seen", target, fb_model0.wr_count);
    end
  endtask

  task automatic apply_sample(input int i);
    int   cycles;
    logic taken;
    if (timed_out) return;
    cycles = 0;
    taken  = 1'b0;
    adc_valid <= 1'b1;
    adc_x     <= stim_x[i];
    adc_y     <= stim_y[i];
    adc_red   <= stim_rgb[i][2];
    adc_grn   <= stim_rgb[i][1];
    adc_blu   <= stim_rgb[i][0];
    // sample stays on the inputs until the edge that accepts it
    while (!taken && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      taken = adc_ready;
      cycles++;
    end
    if (!taken) begin
      errors++;
      timed_out = 1'b1;
      $display("timed out waiting for adc_ready on sample %0d", i);
    end
  endtask

  // wait for the clear sweep and compare every fill write
  task automatic run_clear(input string name);
    int   base;
    int   cycles;
    logic early;
    base   = fb_model0.wr_count;
    cycles = 0;
    early  = 1'b0;
    while (!plotting && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      if (adc_ready && !plotting) early = 1'b1;
      cycles++;
    end
    if (!plotting) begin
      errors++;
      timed_out = 1'b1;
      $display("%s: plotting never went high", name);
      return;
    end
    check_flag({name, " adc_ready before plotting"}, 1'b0, early);
    wait_for_writes(base + FB_WORDS);
    if (timed_out) return;
    for (int i = 0; i < FB_WORDS; i++) begin
      check_addr($sformatf("%s[%0d] addr", name, i), fb_addr_t'(i),
                 fb_model0.log_addr[base + i]);
      check_pixel($sformatf("%s[%0d] pixel", name, i), BLACK,
                  pixel_t'(fb_model0.log_data[base + i]));
      check_flag($sformatf("%s[%0d] pad", name, i), 1'b0,
                 |fb_model0.log_data[base + i][FB_DATA_BITS-1:PIXEL_BITS]);
    end
  endtask

  // **************************************************************************
  // main sequence
  // **************************************************************************

  initial begin
    int err0;
    int base;
    int k;
    int stalls0;
    rst_req      = 1'b0;
    adc_valid    = 1'b0;
    adc_x        = '0;
    adc_y        = '0;
    adc_red      = 1'b0;
    adc_grn      = 1'b0;
    adc_blu      = 1'b0;
    err_at       = -1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    n_stim       = 0;
    n_writes     = 0;

    // first ADC_DELAY rows only fill the colour line
    add_entry(10'd0,    10'd0,    3'b100, 1'b0, 12'h000, 12'h000);
    add_entry(10'd1023, 10'd1023, 3'b010, 1'b0, 12'h000, 12'h000);
    add_entry(10'd512,  10'd256,  3'b001, 1'b0, 12'h000, 12'h000);
    add_entry(10'd0,    10'd0,    3'b111, 1'b1, 12'h000, 12'hF00);
    add_entry(10'd1023, 10'd1023, 3'b000, 1'b1, 12'hBFF, 12'h0F0);
    add_entry(10'd1023, 10'd0,    3'b101, 1'b1, 12'h03F, 12'h00F);
    add_entry(10'd0,    10'd1023, 3'b011, 1'b1, 12'hBC0, 12'hFFF);
    add_entry(10'd512,  10'd512,  3'b110, 1'b1, 12'h620, 12'h000);
    add_entry(10'd100,  10'd700,  3'b100, 1'b1, 12'h806, 12'hF0F);
    add_entry(10'd777,  10'd333,  3'b001, 1'b1, 12'h3F0, 12'h0FF);
    add_entry(10'd15,   10'd21,   3'b010, 1'b1, 12'h000, 12'hFF0);
    add_entry(10'd1008, 10'd22,   3'b111, 1'b1, 12'h07F, 12'hF00);

    err0 = errors;
    run_clear("clear");
    check_flag("clear fb_error", 1'b0, fb_error);
    report_test("clear", err0);

    if (!timed_out) begin
      err0    = errors;
      base    = fb_model0.wr_count;
      stalls0 = fb_model0.stalls;
      for (int i = 0; i < n_stim; i++) apply_sample(i);
      adc_valid <= 1'b0;
      wait_for_writes(base + n_writes);
      // short window to catch duplicated writes
      repeat (16) @(posedge clk);
      k = base;
      for (int i = 0; i < n_stim && !timed_out; i++) begin
        if (stim_wr[i]) begin
          check_addr($sformatf("plot[%0d] addr", i), stim_addr[i], fb_model0.log_addr[k]);
          check_pixel($sformatf("plot[%0d] pixel", i), stim_pix[i],
                      pixel_t'(fb_model0.log_data[k]));
          check_flag($sformatf("plot[%0d] pad", i), 1'b0,
                     |fb_model0.log_data[k][FB_DATA_BITS-1:PIXEL_BITS]);
          k++;
        end
      end
      // black from the clear, then each plotted pixel in table order
      for (int a = 0; a < FB_WORDS; a++) begin
        fb_img[a] = BLACK;
      end
      for (int i = 0; i < n_stim; i++) begin
        if (stim_wr[i]) fb_img[stim_addr[i]] = stim_pix[i];
      end
      for (int a = 0; a < FB_WORDS && !timed_out; a++) begin
        check_pixel($sformatf("fb[%0d]", a), fb_img[a], pixel_t'(fb_model0.mem[a]));
      end
      report_test("plot", err0);

      err0 = errors;
      if (fb_model0.wr_count - base != n_writes) begin
        errors++;
        $display("** Error: backpressure write count expected %0d actual %0d",
                 n_writes, fb_model0.wr_count - base);
      end
      check_flag("backpressure stalls seen", 1'b1, fb_model0.stalls > stalls0);
      report_test("backpressure", err0);
    end

    if (!timed_out) begin
      err0 = errors;
      check_flag("error before", 1'b0, fb_error);
      base = fb_model0.wr_count;
      err_at <= base;
      apply_sample(3);
      adc_valid <= 1'b0;
      wait_for_writes(base + 1);
      check_flag("error set", 1'b1, fb_error);
      err_at <= -1;
      apply_sample(4);
      adc_valid <= 1'b0;
      wait_for_writes(base + 2);
      check_flag("error sticky", 1'b1, fb_error);
      report_test("error", err0);
    end

    if (!timed_out) begin
      err0 = errors;
      apply_sample(5);
      adc_valid <= 1'b0;
      rst_req   <= 1'b1;
      repeat (4) @(posedge clk);
      check_flag("reset plotting", 1'b0, plotting);
      check_flag("reset fb_error", 1'b0, fb_error);
      rst_req <= 1'b0;
      run_clear("reclear");
      report_test("reset", err0);
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
logic/plot_pkg.sv
logic/plot_seq.sv
logic/raster_sweep.sv
logic/adc_xy_sampler.sv
logic/fb_apb_writer.sv
logic/adc_plot_top.sv
dv/tb_clkgen.sv
dv/fb_apb_model.sv
dv/plot_tb.sv

// File: Bender.yml
package:
  name: adc_plot

sources:
  - logic/plot_pkg.sv
  - logic/plot_seq.sv
  - logic/raster_sweep.sv
  - logic/adc_xy_sampler.sv
  - logic/fb_apb_writer.sv
  - logic/adc_plot_top.sv
  - target: simulation
    files:
      - dv/tb_clkgen.sv
      - dv/fb_apb_model.sv
      - dv/plot_tb.sv
